//--- isa_pkg.sv
`default_nettype none

package isa_pkg;

   // ********************
   // widths
   // ********************
   localparam int word_w     = 16;
   localparam int reg_addr_w = 3;
   localparam int num_regs   = 8;

   localparam logic [reg_addr_w-1:0] link_reg = 3'd7; // r7 holds the return address.

   // ********************
   // opcodes
   // ********************
   localparam logic [4:0] op_halt     = 5'b00000;
   localparam logic [4:0] op_nop      = 5'b00001;

   // i-format 1.
   localparam logic [4:0] op_addi     = 5'b01000;
   localparam logic [4:0] op_subi     = 5'b01001;
   localparam logic [4:0] op_xori     = 5'b01010;
   localparam logic [4:0] op_andni    = 5'b01011;
   localparam logic [4:0] op_roli     = 5'b10100;
   localparam logic [4:0] op_slli     = 5'b10101;
   localparam logic [4:0] op_rori     = 5'b10110;
   localparam logic [4:0] op_srli     = 5'b10111;
   localparam logic [4:0] op_st       = 5'b10000;
   localparam logic [4:0] op_ld       = 5'b10001;
   localparam logic [4:0] op_stu      = 5'b10011;

   // i-format 2.
   localparam logic [4:0] op_beqz     = 5'b01100;
   localparam logic [4:0] op_bnez     = 5'b01101;
   localparam logic [4:0] op_bltz     = 5'b01110;
   localparam logic [4:0] op_bgez     = 5'b01111;
   localparam logic [4:0] op_lbi      = 5'b11000;
   localparam logic [4:0] op_slbi     = 5'b10010;
   localparam logic [4:0] op_j        = 5'b00100; // j-format displacement.
   localparam logic [4:0] op_jr       = 5'b00101;
   localparam logic [4:0] op_jal      = 5'b00110; // j-format displacement.
   localparam logic [4:0] op_jalr     = 5'b00111;

   // r-format.
   localparam logic [4:0] op_rr_shift = 5'b11010;
   localparam logic [4:0] op_rr_arith = 5'b11011;
   localparam logic [4:0] op_seq      = 5'b11100;
   localparam logic [4:0] op_slt      = 5'b11101;
   localparam logic [4:0] op_sle      = 5'b11110;

   // function field of r-format words.
   localparam logic [1:0] fn_add  = 2'b00;
   localparam logic [1:0] fn_sub  = 2'b01;
   localparam logic [1:0] fn_xor  = 2'b10;
   localparam logic [1:0] fn_andn = 2'b11;
   localparam logic [1:0] fn_rol  = 2'b00;
   localparam logic [1:0] fn_sll  = 2'b01;
   localparam logic [1:0] fn_ror  = 2'b10;
   localparam logic [1:0] fn_srl  = 2'b11;

   // ********************
   // alu operations
   // ********************
   localparam logic [3:0] alu_add    = 4'd0;
   localparam logic [3:0] alu_sub    = 4'd1;
   localparam logic [3:0] alu_xor    = 4'd2;
   localparam logic [3:0] alu_andn   = 4'd3;
   localparam logic [3:0] alu_rol    = 4'd4;
   localparam logic [3:0] alu_sll    = 4'd5;
   localparam logic [3:0] alu_ror    = 4'd6;
   localparam logic [3:0] alu_srl    = 4'd7;
   localparam logic [3:0] alu_seq    = 4'd8;
   localparam logic [3:0] alu_slt    = 4'd9;
   localparam logic [3:0] alu_sle    = 4'd10;
   localparam logic [3:0] alu_pass_b = 4'd11; // lbi passes the immediate straight through.
   localparam logic [3:0] alu_slbi   = 4'd12; // (a << 8) | b.

   // one word, four formats. opcode always on top.
   typedef union packed {
      struct packed {
         logic [4:0] op;
         logic [2:0] rs;
         logic [2:0] rt;
         logic [2:0] rd;
         logic [1:0] func;
      } r;
      struct packed {
         logic [4:0] op;
         logic [2:0] rs;
         logic [2:0] rd;
         logic [4:0] imm5;
      } i1;
      struct packed {
         logic [4:0] op;
         logic [2:0] rs;
         logic [7:0] imm8;
      } i2;
      struct packed {
         logic [4:0]  op;
         logic [10:0] disp11;
      } j;
   } instr_word_t;

endpackage

`default_nettype wire

//--- instr_reg.sv
`timescale 1ns/1ps
`default_nettype none

module instr_reg
   import isa_pkg::*;
(
   input  wire logic              clk,
   input  wire logic              rst,
   input  wire logic              flush,
   input  wire logic              instr_valid,
   input  wire logic [word_w-1:0] instr,
   output      logic              id_valid,
   output      instr_word_t       id_instr
);

   // valid follows the strobe every cycle, the word only moves on a strobe.
   always_ff @(posedge clk) begin
      if (rst || flush) begin
         id_valid         <= 1'b0;
         id_instr.j.op     <= op_nop; // bubble.
         id_instr.j.disp11 <= '0;
      end else begin
         id_valid <= instr_valid;
         if (instr_valid) begin
            id_instr <= instr;
         end
      end
   end

endmodule

`default_nettype wire

//--- ctrl_decode.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_decode
   import isa_pkg::*;
(
   input  wire instr_word_t           id_instr,
   output      logic [3:0]            alu_op,
   output      logic [reg_addr_w-1:0] dest_reg,
   output      logic                  reg_write,
   output      logic                  mem_read,
   output      logic                  mem_write,
   output      logic                  is_branch,
   output      logic                  is_jump,
   output      logic                  jump_reg,
   output      logic                  illegal
);

   always_comb begin
      // everything idle unless the opcode says otherwise.
      alu_op    = alu_add;
      dest_reg  = '0;
      reg_write = 1'b0;
      mem_read  = 1'b0;
      mem_write = 1'b0;
      is_branch = 1'b0;
      is_jump   = 1'b0;
      jump_reg  = 1'b0;
      illegal   = 1'b0;

      case (id_instr.r.op)
         // ********************
         // i-format 1
         // ********************
         op_addi, op_subi, op_xori, op_andni,
         op_roli, op_slli, op_rori, op_srli: begin
            reg_write = 1'b1;
            dest_reg  = id_instr.i1.rd;
            case (id_instr.i1.op)
               op_subi:  alu_op = alu_sub;
               op_xori:  alu_op = alu_xor;
               op_andni: alu_op = alu_andn;
               op_roli:  alu_op = alu_rol;
               op_slli:  alu_op = alu_sll;
               op_rori:  alu_op = alu_ror;
               op_srli:  alu_op = alu_srl;
               default:  alu_op = alu_add;
            endcase
         end
         op_ld: begin
            reg_write = 1'b1;
            dest_reg  = id_instr.i1.rd;
            mem_read  = 1'b1; // address is rs + imm.
         end
         op_st: mem_write = 1'b1;
         op_stu: begin
            mem_write = 1'b1;
            reg_write = 1'b1; // base register updated.
            dest_reg  = id_instr.i1.rs;
         end

         // ********************
         // i-format 2
         // ********************
         op_lbi, op_slbi: begin
            reg_write = 1'b1;
            dest_reg  = id_instr.i2.rs;
            alu_op    = (id_instr.i2.op == op_lbi) ? alu_pass_b : alu_slbi;
         end
         op_beqz, op_bnez, op_bltz, op_bgez: is_branch = 1'b1;
         op_j: is_jump = 1'b1;
         op_jr: begin
            is_jump  = 1'b1;
            jump_reg = 1'b1;
         end
         op_jal, op_jalr: begin
            is_jump   = 1'b1;
            jump_reg  = (id_instr.r.op == op_jalr);
            reg_write = 1'b1;
            dest_reg  = link_reg;
         end

         // ********************
         // r-format
         // ********************
         op_rr_arith, op_rr_shift, op_seq, op_slt, op_sle: begin
            reg_write = 1'b1;
            dest_reg  = id_instr.r.rd;
            case (id_instr.r.op)
               op_rr_arith: begin
                  case (id_instr.r.func)
                     fn_add:  alu_op = alu_add;
                     fn_sub:  alu_op = alu_sub;
                     fn_xor:  alu_op = alu_xor;
                     fn_andn: alu_op = alu_andn;
                  endcase
               end
               op_rr_shift: begin
                  case (id_instr.r.func)
                     fn_rol: alu_op = alu_rol;
                     fn_sll: alu_op = alu_sll;
                     fn_ror: alu_op = alu_ror;
                     fn_srl: alu_op = alu_srl;
                  endcase
               end
               op_seq:  alu_op = alu_seq;
               op_slt:  alu_op = alu_slt;
               default: alu_op = alu_sle;
            endcase
         end

         op_nop, op_halt: ; // no controls.
         default: illegal = 1'b1; // unknown opcode, nothing written.
      endcase
   end

endmodule

`default_nettype wire

//--- imm_ext.sv
`timescale 1ns/1ps
`default_nettype none

module imm_ext
   import isa_pkg::*;
(
   input  wire instr_word_t       id_instr,
   output      logic [word_w-1:0] imm
);

   logic [4:0] opcode;

   assign opcode = id_instr.r.op;

   // 5b sign   addi, subi, and the ld/st/shift group by default.
   // 5b zero   xori, andni.
   // 8b sign   lbi, jr, jalr, branches.
   // 8b zero   slbi.
   // 11b sign  j, jal.
   always_comb begin
      case (opcode)
         op_j, op_jal: begin
            imm = {{5{id_instr.j.disp11[10]}}, id_instr.j.disp11};
         end

         op_xori, op_andni: begin
            imm = {11'h000, id_instr.i1.imm5}; // logical ops take it unsigned.
         end

         op_lbi, op_jr, op_jalr,
         op_beqz, op_bnez, op_bltz, op_bgez: begin
            imm = {{8{id_instr.i2.imm8[7]}}, id_instr.i2.imm8};
         end

         op_slbi: begin
            imm = {8'h00, id_instr.i2.imm8}; // low byte only.
         end

         // addi, subi, shifts, loads and stores.
         default: begin
            imm = {{11{id_instr.i1.imm5[4]}}, id_instr.i1.imm5};
         end
      endcase
   end

endmodule

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
   import isa_pkg::*;
(
   input  wire logic                  clk,
   input  wire logic                  rst,
   input  wire logic [reg_addr_w-1:0] rs_addr,
   input  wire logic [reg_addr_w-1:0] rt_addr,
   input  wire logic                  wb_en,
   input  wire logic [reg_addr_w-1:0] wb_reg,
   input  wire logic [word_w-1:0]     wb_data,
   output      logic [word_w-1:0]     rs_data,
   output      logic [word_w-1:0]     rt_data
);

   logic [word_w-1:0] regs [num_regs];

   // single write port. r0 is not hardwired.
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < num_regs; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_en) begin
         regs[wb_reg] <= wb_data;
      end
   end

   // ********************
   // reads with bypass
   // ********************
   always_comb begin
      rs_data = regs[rs_addr];
      if (wb_en && (wb_reg == rs_addr)) begin
         rs_data = wb_data; // write-through.
      end

      rt_data = regs[rt_addr];
      if (wb_en && (wb_reg == rt_addr)) begin
         rt_data = wb_data;
      end
   end

endmodule

`default_nettype wire

//--- ex_reg.sv
`timescale 1ns/1ps
`default_nettype none

module ex_reg
   import isa_pkg::*;
(
   input  wire logic                  clk,
   input  wire logic                  rst,
   input  wire logic                  flush,
   input  wire logic                  id_valid,
   input  wire logic [word_w-1:0]     id_rs_data,
   input  wire logic [word_w-1:0]     id_rt_data,
   input  wire logic [word_w-1:0]     id_imm,
   input  wire logic [3:0]            id_alu_op,
   input  wire logic [reg_addr_w-1:0] id_dest_reg,
   input  wire logic                  id_reg_write,
   input  wire logic                  id_mem_read,
   input  wire logic                  id_mem_write,
   input  wire logic                  id_is_branch,
   input  wire logic                  id_is_jump,
   input  wire logic                  id_jump_reg,
   input  wire logic                  id_illegal,
   output      logic                  ex_valid,
   output      logic [word_w-1:0]     rs_data,
   output      logic [word_w-1:0]     rt_data,
   output      logic [word_w-1:0]     imm,
   output      logic [3:0]            alu_op,
   output      logic [reg_addr_w-1:0] dest_reg,
   output      logic                  reg_write,
   output      logic                  mem_read,
   output      logic                  mem_write,
   output      logic                  is_branch,
   output      logic                  is_jump,
   output      logic                  jump_reg,
   output      logic                  illegal
);

   logic kill;

   assign kill = rst || flush || !id_valid; // slot becomes a bubble.

   // control side.
   always_ff @(posedge clk) begin
      ex_valid  <= !kill;
      reg_write <= !kill && id_reg_write;
      mem_read  <= !kill && id_mem_read;
      mem_write <= !kill && id_mem_write;
      is_branch <= !kill && id_is_branch;
      is_jump   <= !kill && id_is_jump;
      jump_reg  <= !kill && id_jump_reg;
      illegal   <= !kill && id_illegal;
   end

   // data side, meaningless while ex_valid is low.
   always_ff @(posedge clk) begin
      if (rst) begin
         rs_data  <= '0;
         rt_data  <= '0;
         imm      <= '0;
         alu_op   <= '0;
         dest_reg <= '0;
      end else begin
         rs_data  <= id_rs_data;
         rt_data  <= id_rt_data;
         imm      <= id_imm;
         alu_op   <= id_alu_op;
         dest_reg <= id_dest_reg;
      end
   end

endmodule

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage
   import isa_pkg::*;
(
   input  wire logic                  clk,
   input  wire logic                  rst,
   input  wire logic                  instr_valid,
   input  wire logic [word_w-1:0]     instr,
   input  wire logic                  flush,
   input  wire logic                  wb_en,
   input  wire logic [reg_addr_w-1:0] wb_reg,
   input  wire logic [word_w-1:0]     wb_data,
   output      logic                  ex_valid,
   output      logic [word_w-1:0]     rs_data,
   output      logic [word_w-1:0]     rt_data,
   output      logic [word_w-1:0]     imm,
   output      logic [3:0]            alu_op,
   output      logic [reg_addr_w-1:0] dest_reg,
   output      logic                  reg_write,
   output      logic                  mem_read,
   output      logic                  mem_write,
   output      logic                  is_branch,
   output      logic                  is_jump,
   output      logic                  jump_reg,
   output      logic                  illegal
);

   // ********************
   // decode-side wires
   // ********************
   logic                  id_valid;
   instr_word_t           id_instr;
   logic [word_w-1:0]     id_rs_data;
   logic [word_w-1:0]     id_rt_data;
   logic [word_w-1:0]     id_imm;
   logic [3:0]            id_alu_op;
   logic [reg_addr_w-1:0] id_dest_reg;
   logic                  id_reg_write;
   logic                  id_mem_read;
   logic                  id_mem_write;
   logic                  id_is_branch;
   logic                  id_is_jump;
   logic                  id_jump_reg;
   logic                  id_illegal;

   instr_reg u_instr_reg (
      .clk(clk), .rst(rst), .flush(flush),
      .instr_valid(instr_valid), .instr(instr),
      .id_valid(id_valid), .id_instr(id_instr)
   );

   ctrl_decode u_ctrl_decode (
      .id_instr(id_instr), .alu_op(id_alu_op), .dest_reg(id_dest_reg),
      .reg_write(id_reg_write), .mem_read(id_mem_read), .mem_write(id_mem_write),
      .is_branch(id_is_branch), .is_jump(id_is_jump), .jump_reg(id_jump_reg),
      .illegal(id_illegal)
   );

   imm_ext u_imm_ext (.id_instr(id_instr), .imm(id_imm));

   // rs and rt sit at the same bits in every format that reads them.
   reg_file u_reg_file (
      .clk(clk), .rst(rst), .rs_addr(id_instr.r.rs), .rt_addr(id_instr.r.rt),
      .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data),
      .rs_data(id_rs_data), .rt_data(id_rt_data)
   );

   ex_reg u_ex_reg (
      .clk(clk), .rst(rst), .flush(flush), .id_valid(id_valid),
      .id_rs_data(id_rs_data), .id_rt_data(id_rt_data), .id_imm(id_imm),
      .id_alu_op(id_alu_op), .id_dest_reg(id_dest_reg), .id_reg_write(id_reg_write),
      .id_mem_read(id_mem_read), .id_mem_write(id_mem_write),
      .id_is_branch(id_is_branch), .id_is_jump(id_is_jump),
      .id_jump_reg(id_jump_reg), .id_illegal(id_illegal),
      .ex_valid(ex_valid), .rs_data(rs_data), .rt_data(rt_data), .imm(imm),
      .alu_op(alu_op), .dest_reg(dest_reg), .reg_write(reg_write),
      .mem_read(mem_read), .mem_write(mem_write), .is_branch(is_branch),
      .is_jump(is_jump), .jump_reg(jump_reg), .illegal(illegal)
   );

endmodule

`default_nettype wire

//--- decode_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module decode_assertions (
   input wire logic clk,
   input wire logic rst,
   input wire logic instr_valid,
   input wire logic flush,
   input wire logic ex_valid,
   input wire logic reg_write,
   input wire logic mem_read,
   input wire logic mem_write,
   input wire logic is_branch,
   input wire logic is_jump,
   input wire logic jump_reg,
   input wire logic illegal
);

   logic any_ctrl;

   assign any_ctrl = reg_write || mem_read || mem_write || is_branch ||
                     is_jump || jump_reg || illegal;

   // a bubble carries no controls.
   bubble_quiet: assert property (@(posedge clk) disable iff (rst) !ex_valid |-> !any_ctrl)
      else $error("control output high while ex_valid is low");

   no_illegal_write: assert property (@(posedge clk) disable iff (rst) !(reg_write && illegal))
      else $error("reg_write and illegal high together");

   // accepted two edges back and not flushed on either edge.
   two_cycle_valid: assert property (@(posedge clk) disable iff (rst)
      ex_valid == ($past(instr_valid && !flush, 2) && !$past(flush)))
      else $error("ex_valid does not follow instr_valid after two cycles");

endmodule

`default_nettype wire

//--- tb_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage
   import isa_pkg::*;
();

   localparam int num_cycles  = 3000;
   localparam int drain_limit = 10;

   localparam logic [4:0] legal_ops [28] = '{
      op_addi, op_subi, op_xori, op_andni, op_roli, op_slli, op_rori, op_srli,
      op_st, op_ld, op_stu, op_beqz, op_bnez, op_bltz, op_bgez, op_lbi, op_slbi,
      op_j, op_jr, op_jal, op_jalr, op_rr_arith, op_rr_shift, op_seq, op_slt, op_sle,
      op_nop, op_halt
   };
   localparam logic [3:0] arith_codes [4] = '{alu_add, alu_sub, alu_xor, alu_andn};
   localparam logic [3:0] shift_codes [4] = '{alu_rol, alu_sll, alu_ror, alu_srl};

   logic                  clk;
   logic                  rst;
   logic                  instr_valid;
   logic [word_w-1:0]     instr;
   logic                  flush;
   logic                  wb_en;
   logic [reg_addr_w-1:0] wb_reg;
   logic [word_w-1:0]     wb_data;
   logic                  ex_valid;
   logic [word_w-1:0]     rs_data;
   logic [word_w-1:0]     rt_data;
   logic [word_w-1:0]     imm;
   logic [3:0]            alu_op;
   logic [reg_addr_w-1:0] dest_reg;
   logic                  reg_write;
   logic                  mem_read;
   logic                  mem_write;
   logic                  is_branch;
   logic                  is_jump;
   logic                  jump_reg;
   logic                  illegal;

   // ********************
   // reference model state
   // ********************
   logic [word_w-1:0]     shadow [num_regs];
   logic                  id_v; // id stage slot.
   logic [word_w-1:0]     id_w;
   logic                  e_valid; // what ex should hold after the last edge.
   logic [word_w-1:0]     e_rs;
   logic [word_w-1:0]     e_rt;
   logic [word_w-1:0]     e_imm;
   logic [3:0]            e_alu;
   logic                  e_alu_chk;
   logic [reg_addr_w-1:0] e_dest;
   logic                  e_reg_write;
   logic                  e_mem_read;
   logic                  e_mem_write;
   logic                  e_branch;
   logic                  e_jump;
   logic                  e_jump_reg;
   logic                  e_illegal;
   int                    waited;

   decode_stage dut0 (.*);

   bind decode_stage decode_assertions u_decode_assertions (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic abort_run();
      $display("Test failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_bit(input string name, input logic got, input logic want);
      assert (got === want) else begin
         $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, want);
         abort_run();
      end
   endtask

   task automatic check_word(input string name, input logic [15:0] got, input logic [15:0] want);
      assert (got === want) else begin
         $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, want);
         abort_run();
      end
   endtask

   function automatic logic [word_w-1:0] read_reg(input logic [2:0] a, input logic we,
                                                  input logic [2:0] wr, input logic [15:0] wd);
      if (we && (wr == a)) begin
         return wd; // same-cycle write wins.
      end else begin
         return shadow[a];
      end
   endfunction

   // expected controls and immediate for one instruction word.
   task automatic expect_decode(input logic [word_w-1:0] w);
      logic [4:0] op;
      logic       legal;
      op    = w[15:11];
      legal = 1'b0;
      foreach (legal_ops[k]) begin
         if (legal_ops[k] == op) begin
            legal = 1'b1;
         end
      end
      e_illegal   = !legal;
      e_reg_write = 1'b0;
      e_dest      = '0;
      e_mem_read  = (op == op_ld);
      e_mem_write = (op == op_st) || (op == op_stu);
      e_branch    = op inside {op_beqz, op_bnez, op_bltz, op_bgez};
      e_jump      = op inside {op_j, op_jr, op_jal, op_jalr};
      e_jump_reg  = (op == op_jr) || (op == op_jalr);

      if (op inside {op_addi, op_subi, op_xori, op_andni, op_roli, op_slli,
                     op_rori, op_srli, op_ld}) begin
         e_reg_write = 1'b1;
         e_dest      = w[7:5];
      end else if (op inside {op_rr_arith, op_rr_shift, op_seq, op_slt, op_sle}) begin
         e_reg_write = 1'b1;
         e_dest      = w[4:2];
      end else if (op inside {op_lbi, op_slbi, op_stu}) begin
         e_reg_write = 1'b1;
         e_dest      = w[10:8];
      end else if (op inside {op_jal, op_jalr}) begin
         e_reg_write = 1'b1;
         e_dest      = link_reg;
      end

      e_alu_chk = 1'b1;
      e_alu     = alu_add;
      case (op)
         op_addi:     e_alu = alu_add;
         op_subi:     e_alu = alu_sub;
         op_xori:     e_alu = alu_xor;
         op_andni:    e_alu = alu_andn;
         op_roli:     e_alu = alu_rol;
         op_slli:     e_alu = alu_sll;
         op_rori:     e_alu = alu_ror;
         op_srli:     e_alu = alu_srl;
         op_rr_arith: e_alu = arith_codes[w[1:0]];
         op_rr_shift: e_alu = shift_codes[w[1:0]];
         op_seq:      e_alu = alu_seq;
         op_slt:      e_alu = alu_slt;
         op_sle:      e_alu = alu_sle;
         op_lbi:      e_alu = alu_pass_b;
         op_slbi:     e_alu = alu_slbi;
         default:     e_alu_chk = 1'b0; // no alu code defined.
      endcase

      case (op)
         op_xori, op_andni: e_imm = {11'd0, w[4:0]};
         op_lbi, op_jr, op_jalr, op_beqz, op_bnez, op_bltz, op_bgez: begin
            e_imm = {{8{w[7]}}, w[7:0]};
         end
         op_slbi:           e_imm = {8'd0, w[7:0]};
         op_j, op_jal:      e_imm = {{5{w[10]}}, w[10:0]};
         default:           e_imm = {{11{w[4]}}, w[4:0]};
      endcase
   endtask

   // one rising edge of the model, fed with the inputs the DUT samples.
   task automatic model_edge(input logic iv, input logic [15:0] iw, input logic fl,
                             input logic we, input logic [2:0] wr, input logic [15:0] wd);
      e_valid = id_v && !fl;
      expect_decode(id_w);
      e_rs = read_reg(id_w[10:8], we, wr, wd);
      e_rt = read_reg(id_w[7:5], we, wr, wd);
      if (we) begin
         shadow[wr] = wd;
      end
      id_v = iv && !fl;
      if (fl) begin
         id_w = {op_nop, 11'd0};
      end else if (iv) begin
         id_w = iw;
      end
   endtask

   task automatic check_outputs();
      check_bit("ex_valid", ex_valid, e_valid);
      check_bit("reg_write", reg_write, e_valid && e_reg_write);
      check_bit("mem_read", mem_read, e_valid && e_mem_read);
      check_bit("mem_write", mem_write, e_valid && e_mem_write);
      check_bit("is_branch", is_branch, e_valid && e_branch);
      check_bit("is_jump", is_jump, e_valid && e_jump);
      check_bit("jump_reg", jump_reg, e_valid && e_jump_reg);
      check_bit("illegal", illegal, e_valid && e_illegal);
      if (e_valid) begin
         check_word("rs_data", rs_data, e_rs);
         check_word("rt_data", rt_data, e_rt);
         check_word("imm", imm, e_imm);
         if (e_alu_chk) begin
            check_word("alu_op", 16'(alu_op), 16'(e_alu));
         end
         if (e_reg_write) begin
            check_word("dest_reg", 16'(dest_reg), 16'(e_dest));
         end
      end
   endtask

   // drive at a rising edge, check at the falling edge, model the next rising edge.
   task automatic run_cycle(input logic iv, input logic [15:0] iw, input logic fl,
                            input logic we, input logic [2:0] wr, input logic [15:0] wd);
      instr_valid <= iv;
      instr       <= iw;
      flush       <= fl;
      wb_en       <= we;
      wb_reg      <= wr;
      wb_data     <= wd;
      @(negedge clk);
      check_outputs();
      @(posedge clk);
      model_edge(iv, iw, fl, we, wr, wd);
   endtask

   function automatic logic [word_w-1:0] random_word();
      logic [word_w-1:0] w;
      w = 16'($urandom());
      if ($urandom_range(0, 99) < 80) begin
         w[15:11] = legal_ops[5'($urandom_range(0, 27))];
         if ($urandom_range(0, 99) < 30) begin
            w[10] = 1'b1; // negative disp11.
            w[7]  = 1'b1; // negative imm8.
            w[4]  = 1'b1; // negative imm5.
         end
      end
      return w;
   endfunction

   initial begin
      void'($urandom(32'h7c2f));
      rst         <= 1'b1;
      instr_valid <= 1'b0;
      instr       <= '0;
      flush       <= 1'b0;
      wb_en       <= 1'b0;
      wb_reg      <= '0;
      wb_data     <= '0;
      id_v        = 1'b0;
      id_w        = {op_nop, 11'd0};
      e_valid     = 1'b0;
      foreach (shadow[i]) begin
         shadow[i] = '0;
      end

      repeat (2) @(posedge clk);
      rst <= 1'b0;

      // ********************
      // reset state
      // ********************
      @(negedge clk);
      check_outputs();
      check_word("rs_data", rs_data, '0);
      check_word("rt_data", rt_data, '0);
      check_word("imm", imm, '0);
      check_word("alu_op", 16'(alu_op), '0);
      check_word("dest_reg", 16'(dest_reg), '0);
      @(posedge clk);
      model_edge(1'b0, '0, 1'b0, 1'b0, 3'd0, '0);

      // every register read once, nothing written yet.
      for (int k = 0; k < 4; k++) begin
         run_cycle(1'b1, {op_rr_arith, 3'(2 * k), 3'(2 * k + 1), 3'd1, 2'b00},
                   1'b0, 1'b0, 3'd0, '0);
      end

      // ********************
      // random traffic
      // ********************
      for (int n = 0; n < num_cycles; n++) begin
         run_cycle($urandom_range(0, 99) < 75, random_word(), $urandom_range(0, 99) < 5,
                   $urandom_range(0, 99) < 40, 3'($urandom()), 16'($urandom()));
      end

      waited = 0;
      while (id_v || e_valid) begin
         if (waited == drain_limit) begin
            $display("pipeline still holds an instruction after %0d idle cycles", waited);
            abort_run();
         end else begin
            run_cycle(1'b0, '0, 1'b0, 1'b0, 3'd0, '0);
            waited++;
         end
      end
      @(negedge clk);
      check_outputs();

      $display("Test completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

//--- files.f
isa_pkg.sv
instr_reg.sv
ctrl_decode.sv
imm_ext.sv
reg_file.sv
ex_reg.sv
decode_stage.sv
decode_assertions.sv
tb_decode_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the decode stage testbench with verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert \
   --timescale 1ns/1ps \
   -f files.f \
   --top-module tb_decode_stage \
   -o sim_decode

./obj_dir/sim_decode | tee sim.log

if grep -qx "Test completed successfully" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
